//--- all.f
+incdir+common
common/mem_pkg.sv
rtl/mem_ctrl.sv
dcache/dcache_ram.sv
dcache/dcache_ctrl.sv
rtl/mem_reg.sv
rtl/mem_stage.sv
tb/l2_model.sv
tb/tb_mem_stage.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the memory stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f all.f \
    --top-module tb_mem_stage \
    -o sim_mem_stage

# simulation output goes to the terminal, the grep decides the status
./obj_dir/sim_mem_stage | tee /dev/stderr | grep -q "^STATUS: PASS$"
echo "simulation passed"

//--- tb/tb_mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_macros.svh"

module tb_mem_stage;
    import mem_pkg::*;

    localparam int num_random   = 400;
    localparam int num_directed = 20;
    localparam int cycle_limit  = 300 * (num_random + num_directed) + 256 + 16;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    stall;
    logic                    flush;
    logic                    miss_stall;
    logic                    l2_rdy;
    logic [`MEM_LINE_W-1:0]  l2_rd_line;
    logic [`MEM_WORD_W-1:0]  fwd_data;
    ex_mem_t                 ex;
    mem_wb_t                 mem;
    l2_req_t                 l2_req;

    logic [31:0]  gold [logic [31:0]];     // words stored so far
    mem_wb_t      exp_wb = '0;             // expected mem/wb contents
    logic         check_on = 1'b0;
    logic         drq_seen = 1'b0;
    logic [31:0]  last_wb_addr = '0;
    int           wb_errs = 0;
    int           fwd_errs = 0;
    int           l2_errs = 0;
    int           misc_errs = 0;
    int           cycles = 0;
    int           l2_reqs = 0;
    int           wb_count = 0;

    // tag state the stage should hold after the init walk
    logic [`MEM_TAG_W-1:0]  mdl_tag   [256][2];
    logic                   mdl_valid [256][2];
    logic                   mdl_dirty [256][2];
    logic                   mdl_lru   [256];             // way to replace next
    l2_req_t                exp_l2    [$];               // line requests still to come

    mem_stage i_mem_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .flush      (flush),
        .ex         (ex),
        .miss_stall (miss_stall),
        .fwd_data   (fwd_data),
        .mem        (mem),
        .l2_req     (l2_req),
        .l2_rdy     (l2_rdy),
        .l2_rd_line (l2_rd_line)
    );

    l2_model i_l2_model (
        .clk        (clk),
        .rst_n      (rst_n),
        .l2_req     (l2_req),
        .l2_rdy     (l2_rdy),
        .l2_rd_line (l2_rd_line)
    );

    initial begin
        forever #20 clk = ~clk;                          // 40 ns period
    end

    // same pattern as the l2 fill
    function automatic logic [31:0] word_hash(input logic [31:0] addr);
        return ((addr ^ 32'h5bd1_e995) * 32'h0001_0193) + {addr[15:0], addr[31:16]};
    endfunction

    function automatic logic [31:0] gold_word(input logic [31:0] addr);
        if (gold.exists(addr)) return gold[addr];
        return word_hash(addr);
    endfunction

    function automatic logic [127:0] gold_line(input logic [31:0] addr);
        logic [127:0] line;
        for (int i = 0; i < 4; i++) line[32*i +: 32] = gold_word({addr[31:4], 4'h0} + 32'(i * 4));
        return line;
    endfunction

    // expected mem/wb contents for one slot
    function automatic mem_wb_t expect_wb(input ex_mem_t s);
        mem_wb_t r;
        logic    mis;
        mis = s.en && (s.op == op_load || s.op == op_store) && (s.ex_out[1:0] != 2'b00);
        r.en         = s.en;
        r.dst_addr   = s.dst_addr;
        r.gpr_we     = s.gpr_we && !mis;
        r.miss_align = mis;
        r.out        = (s.en && s.op == op_load && !mis) ? gold_word(s.ex_out) : s.ex_out;
        return r;
    endfunction

    function automatic ex_mem_t make_op(input mem_op_e op, input logic [31:0] addr,
                                        input logic [31:0] data, input logic [4:0] dst);
        ex_mem_t s;
        s.en       = 1'b1;
        s.op       = op;
        s.wr_data  = data;
        s.ex_out   = addr;
        s.dst_addr = dst;
        s.gpr_we   = (op != op_store);
        return s;
    endfunction

    // two-way lru model, queues the line traffic one access must raise
    task automatic predict_l2(input ex_mem_t s);
        l2_req_t                  q;
        logic [`MEM_INDEX_W-1:0]  set_idx;
        logic [`MEM_TAG_W-1:0]    tag;
        int                       way;
        set_idx = s.ex_out[11:4];
        tag     = s.ex_out[31:12];
        if (s.en && (s.op == op_load || s.op == op_store) && s.ex_out[1:0] == 2'b00) begin
            if (mdl_valid[set_idx][0] && mdl_tag[set_idx][0] == tag) begin
                way = 0;
            end else if (mdl_valid[set_idx][1] && mdl_tag[set_idx][1] == tag) begin
                way = 1;
            end else begin
                way = mdl_lru[set_idx];                      // miss, replace the lru way
                if (mdl_valid[set_idx][way] && mdl_dirty[set_idx][way]) begin
                    q.drq     = 1'b1;                        // dirty victim goes first
                    q.rw      = 1'b1;
                    q.addr    = {mdl_tag[set_idx][way], set_idx, 4'h0};
                    q.wr_line = gold_line(q.addr);
                    exp_l2.push_back(q);
                end
                q.drq     = 1'b1;
                q.rw      = 1'b0;
                q.addr    = {tag, set_idx, 4'h0};
                q.wr_line = '0;
                exp_l2.push_back(q);
                mdl_valid[set_idx][way] = 1'b1;
                mdl_tag[set_idx][way]   = tag;
                mdl_dirty[set_idx][way] = 1'b0;
            end
            if (s.op == op_store) mdl_dirty[set_idx][way] = 1'b1;
            mdl_lru[set_idx] = (way == 0);                   // point away from the used way
        end
    endtask

    task automatic check_wb(input mem_wb_t exp, input mem_wb_t got);
        if (got.en !== exp.en) begin
            $display("Fail mem.en got %h expected %h at %0t", got.en, exp.en, $time);
            wb_errs++;
        end
        if (got.gpr_we !== exp.gpr_we) begin
            $display("Fail mem.gpr_we got %h expected %h at %0t", got.gpr_we, exp.gpr_we, $time);
            wb_errs++;
        end
        if (got.miss_align !== exp.miss_align) begin
            $display("Fail mem.miss_align got %h expected %h", got.miss_align, exp.miss_align);
            wb_errs++;
        end
        if (exp.en && got.dst_addr !== exp.dst_addr) begin
            $display("Fail mem.dst_addr got %h expected %h", got.dst_addr, exp.dst_addr);
            wb_errs++;
        end
        if (exp.en && got.out !== exp.out) begin
            $display("Fail mem.out got %h expected %h at %0t", got.out, exp.out, $time);
            wb_errs++;
        end
    endtask

    task automatic check_fwd(input logic [`MEM_WORD_W-1:0] exp,
                             input logic [`MEM_WORD_W-1:0] got);
        if (got !== exp) begin
            $display("Fail fwd_data got %h expected %h at %0t", got, exp, $time);
            fwd_errs++;
        end
    endtask

    task automatic check_l2(input l2_req_t exp, input l2_req_t got);
        if (got.rw !== exp.rw) begin
            $display("Fail l2_req.rw got %h expected %h", got.rw, exp.rw);
            l2_errs++;
        end
        if (got.addr !== exp.addr) begin
            $display("Fail l2_req.addr got %h expected %h", got.addr, exp.addr);
            l2_errs++;
        end
        if (exp.rw && got.wr_line !== exp.wr_line) begin
            $display("Fail l2_req.wr_line got %h expected %h", got.wr_line, exp.wr_line);
            l2_errs++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got !== exp) begin
            $display("Fail %s got %h expected %h", name, got, exp);
            misc_errs++;
        end
    endtask

    // present one slot and wait until the stage takes it
    task automatic issue(input ex_mem_t s, input logic st, input logic fl, output int waits);
        logic done;
        done  = 1'b0;
        waits = 0;
        predict_l2(s);
        ex    <= s;
        stall <= st;                                     // stall only in the first cycle
        flush <= fl;
        while (!done) begin
            @(negedge clk);
            done = !miss_stall && !stall;
            if (miss_stall) waits++;
            @(posedge clk);
            if (!done) stall <= 1'b0;
        end
        if (s.en && s.op == op_store && s.ex_out[1:0] == 2'b00) gold[s.ex_out] = s.wr_data;
    endtask

    // mem/wb model, checked mid-cycle
    always @(negedge clk) begin
        mem_wb_t nxt;
        if (check_on) begin
            check_wb(exp_wb, mem);
            nxt = expect_wb(ex);
            if (!miss_stall) check_fwd(nxt.out, fwd_data);   // forward path, same cycle
            if (!stall) begin
                if (flush || miss_stall) begin
                    exp_wb.en         = 1'b0;                // bubble or flushed slot
                    exp_wb.gpr_we     = 1'b0;
                    exp_wb.miss_align = 1'b0;
                end else begin
                    exp_wb = nxt;
                end
            end
        end
    end

    // l2 request monitor, one check per rising drq
    always @(negedge clk) begin
        l2_req_t exp;
        if (rst_n && l2_req.drq && !drq_seen) begin
            l2_reqs++;
            if (exp_l2.size() == 0) begin
                $display("l2 request raised with no access waiting for one at %0t", $time);
                l2_errs++;
            end else begin
                exp = exp_l2.pop_front();
                check_l2(exp, l2_req);
            end
            if (l2_req.rw) begin
                wb_count++;
                last_wb_addr = l2_req.addr;
            end
        end
        drq_seen = l2_req.drq;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout, run passed %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        int           waits;
        int           r0;
        int unsigned  r;
        ex_mem_t      s;
        logic [31:0]  a0;
        logic [7:0]   idx;
        void'($urandom(32'h1cae_b33a));
        rst_n = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        ex    = '0;
        for (int i = 0; i < 256; i++) begin              // all sets empty after the walk
            mdl_valid[i][0] = 1'b0;
            mdl_valid[i][1] = 1'b0;
            mdl_lru[i]      = 1'b0;
        end
        repeat (16) @(posedge clk);
        rst_n    <= 1'b1;
        check_on <= 1'b1;
        @(negedge clk);
        while (miss_stall) @(negedge clk);               // init walk
        @(posedge clk);

        r0 = l2_reqs;                                    // nop, no cache traffic
        issue(make_op(op_nop, 32'h1234_5678, 32'h0, 5'd3), 1'b0, 1'b0, waits);
        check_count("nop miss_stall cycles", waits, 0);
        check_count("nop l2 requests", l2_reqs - r0, 0);

        a0 = {20'h0_0abc, 8'h23, 2'd1, 2'b00};           // cold load
        issue(make_op(op_load, a0, 32'h0, 5'd4), 1'b0, 1'b0, waits);
        check_count("cold load l2 requests", l2_reqs - r0, 1);

        r0 = l2_reqs;                                    // store then load, line resident
        issue(make_op(op_store, a0, 32'hdead_beef, 5'd0), 1'b0, 1'b0, waits);
        issue(make_op(op_load, a0, 32'h0, 5'd5), 1'b0, 1'b0, waits);
        check_count("resident line l2 requests", l2_reqs - r0, 0);

        idx = 8'h40;                                     // three tags on one set
        issue(make_op(op_store, {20'h0_0011, idx, 4'h0}, 32'haaaa_0001, 5'd0), 1'b0, 1'b0, waits);
        issue(make_op(op_load, {20'h0_0011, idx, 4'h0}, 32'h0, 5'd6), 1'b0, 1'b0, waits);
        issue(make_op(op_store, {20'h0_0022, idx, 4'h4}, 32'haaaa_0002, 5'd0), 1'b0, 1'b0, waits);
        issue(make_op(op_load, {20'h0_0022, idx, 4'h4}, 32'h0, 5'd7), 1'b0, 1'b0, waits);
        r0 = wb_count;
        issue(make_op(op_store, {20'h0_0033, idx, 4'h8}, 32'haaaa_0003, 5'd0), 1'b0, 1'b0, waits);
        check_count("eviction writebacks", wb_count - r0, 1);
        check_count("evicted line address", last_wb_addr, {20'h0_0011, idx, 4'h0});
        issue(make_op(op_load, {20'h0_0033, idx, 4'h8}, 32'h0, 5'd8), 1'b0, 1'b0, waits);
        issue(make_op(op_load, {20'h0_0011, idx, 4'h0}, 32'h0, 5'd9), 1'b0, 1'b0, waits);

        r0 = l2_reqs;                                    // misaligned, no access
        issue(make_op(op_load, a0 + 32'd1, 32'h0, 5'd10), 1'b0, 1'b0, waits);
        check_count("misaligned load miss_stall cycles", waits, 0);
        issue(make_op(op_store, a0 + 32'd2, 32'h5555_aaaa, 5'd0), 1'b0, 1'b0, waits);
        check_count("misaligned store miss_stall cycles", waits, 0);
        check_count("misaligned l2 requests", l2_reqs - r0, 0);

        issue(make_op(op_load, a0, 32'h0, 5'd11), 1'b1, 1'b0, waits);   // held one cycle
        issue(make_op(op_nop, 32'h0bad_f00d, 32'h0, 5'd12), 1'b0, 1'b1, waits);

        for (int n = 0; n < num_random; n++) begin       // 4 sets, 6 tags
            r            = $urandom;
            s.op         = mem_op_e'(r % 3);
            s.en         = (r[7:5] != 3'd0);
            s.gpr_we     = r[8];
            s.dst_addr   = r[13:9];
            s.wr_data    = $urandom;
            s.ex_out     = {20'h0_1000 + 20'($urandom % 6) * 20'h0_0345,
                            8'h10 + 8'($urandom % 4) * 8'h21, 2'($urandom % 4), 2'b00};
            if ($urandom % 16 == 0) s.ex_out[1:0] = 2'($urandom % 3 + 1);
            issue(s, ($urandom % 8 == 0), ($urandom % 8 == 0), waits);
        end

        issue('0, 1'b0, 1'b0, waits);                    // drain
        repeat (2) @(posedge clk);
        check_count("l2 requests never raised", exp_l2.size(), 0);
        $display("errors: mem_wb %0d, fwd %0d, l2 %0d, other %0d",
                 wb_errs, fwd_errs, l2_errs, misc_errs);
        if (wb_errs + fwd_errs + l2_errs + misc_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/l2_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_macros.svh"

module l2_model (
    input  logic                    clk,
    input  logic                    rst_n,
    input  mem_pkg::l2_req_t        l2_req,      // line request from the cache
    output logic                    l2_rdy,      // one cycle pulse
    output logic [`MEM_LINE_W-1:0]  l2_rd_line   // valid with l2_rdy
);
    import mem_pkg::*;

    logic [31:0]             words [logic [31:0]];  // sparse backing store
    logic                    busy   = 1'b0;
    logic                    rdy_q  = 1'b0;
    logic [`MEM_LINE_W-1:0]  line_q = '0;
    int unsigned             wait_cnt = 0;

    // fill pattern, every address bit counts
    function automatic logic [31:0] word_hash(input logic [31:0] addr);
        return ((addr ^ 32'h5bd1_e995) * 32'h0001_0193) + {addr[15:0], addr[31:16]};
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (words.exists(addr)) return words[addr];
        return word_hash(addr);
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            rdy_q <= 1'b0;
        end else begin
            rdy_q <= 1'b0;                                   // pulse lasts one cycle
            if (busy) begin
                if (wait_cnt == 0) begin
                    busy  <= 1'b0;
                    rdy_q <= 1'b1;
                    for (int i = 0; i < 4; i++) begin
                        if (l2_req.rw) words[l2_req.addr + 32'(i * 4)] = l2_req.wr_line[32*i +: 32];
                        else line_q[32*i +: 32] <= read_word(l2_req.addr + 32'(i * 4));
                    end
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end else if (l2_req.drq && !rdy_q) begin         // drq still high in the pulse cycle
                busy     <= 1'b1;
                wait_cnt <= $urandom_range(7, 0);            // 2 to 9 cycles drq to rdy
            end
        end
    end

    assign l2_rdy     = rdy_q;
    assign l2_rd_line = line_q;

endmodule

`default_nettype wire

//--- rtl/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_macros.svh"

module mem_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    stall,       // pipeline stall
    input  logic                    flush,       // pipeline flush
    input  mem_pkg::ex_mem_t        ex,          // ex/mem register
    output logic                    miss_stall,  // cache miss or init walk
    output logic [`MEM_WORD_W-1:0]  fwd_data,    // forward path
    output mem_pkg::mem_wb_t        mem,         // mem/wb register
    output mem_pkg::l2_req_t        l2_req,
    input  logic                    l2_rdy,
    input  logic [`MEM_LINE_W-1:0]  l2_rd_line
);
    import mem_pkg::*;

    cache_req_t                req;
    logic                      miss_align;
    logic [`MEM_ADDR_W-1:0]    addr_out;
    logic [`MEM_WORD_W-1:0]    rd_word;
    logic [`MEM_INDEX_W-1:0]   index;
    way_rd_t                   way0;
    way_rd_t                   way1;
    logic                      lru;
    way_wr_t                   wr;
    logic                      wr_en;
    logic                      lru_we;
    logic                      lru_val;

    mem_ctrl i_mem_ctrl (
        .ex         (ex),
        .req        (req),
        .miss_align (miss_align),
        .addr_out   (addr_out)
    );

    dcache_ctrl i_dcache_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .rd_word    (rd_word),
        .miss_stall (miss_stall),
        .index      (index),
        .way0       (way0),
        .way1       (way1),
        .lru        (lru),
        .wr         (wr),
        .wr_en      (wr_en),
        .lru_we     (lru_we),
        .lru_val    (lru_val),
        .l2_req     (l2_req),
        .l2_rdy     (l2_rdy),
        .l2_rd_line (l2_rd_line)
    );

    dcache_ram i_dcache_ram (
        .clk     (clk),
        .index   (index),
        .way0    (way0),
        .way1    (way1),
        .lru     (lru),
        .wr      (wr),
        .wr_en   (wr_en),
        .lru_we  (lru_we),
        .lru_val (lru_val)
    );

    // load word for loads, alu result for everything else
    assign fwd_data = (req.access && !req.write) ? rd_word : addr_out;

    mem_reg i_mem_reg (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .flush      (flush),
        .bubble     (miss_stall),                // empty slot while the miss runs
        .ex         (ex),
        .out        (fwd_data),
        .miss_align (miss_align),
        .mem        (mem)
    );

endmodule

`default_nettype wire

//--- rtl/mem_reg.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_macros.svh"

module mem_reg (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    stall,       // back-pressure, hold
    input  logic                    flush,       // kill the slot
    input  logic                    bubble,      // cache miss in progress
    input  mem_pkg::ex_mem_t        ex,
    input  logic [`MEM_WORD_W-1:0]  out,         // load data or alu result
    input  logic                    miss_align,
    output mem_pkg::mem_wb_t        mem
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem.en         <= 1'b0;
            mem.gpr_we     <= 1'b0;
            mem.miss_align <= 1'b0;
        end else if (stall) begin
            mem <= mem;                              // hold, stall wins over flush
        end else if (flush || bubble) begin
            mem.en         <= 1'b0;                  // empty slot
            mem.gpr_we     <= 1'b0;
            mem.miss_align <= 1'b0;
        end else begin
            mem.en         <= ex.en;
            mem.dst_addr   <= ex.dst_addr;
            mem.gpr_we     <= ex.gpr_we && !miss_align;  // no write on misalign
            mem.out        <= out;
            mem.miss_align <= miss_align;
        end
    end

endmodule

`default_nettype wire

//--- dcache/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_macros.svh"

module dcache_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  mem_pkg::cache_req_t      req,         // decoded access, held during a miss
    output logic [`MEM_WORD_W-1:0]   rd_word,     // hit word
    output logic                     miss_stall,  // pipeline stall
    output logic [`MEM_INDEX_W-1:0]  index,       // set to storage
    input  mem_pkg::way_rd_t         way0,
    input  mem_pkg::way_rd_t         way1,
    input  logic                     lru,         // way to replace next
    output mem_pkg::way_wr_t         wr,
    output logic                     wr_en,
    output logic                     lru_we,
    output logic                     lru_val,
    output mem_pkg::l2_req_t         l2_req,
    input  logic                     l2_rdy,      // one cycle pulse
    input  logic [`MEM_LINE_W-1:0]   l2_rd_line   // valid with l2_rdy
);
    import mem_pkg::*;

    localparam int low_w = `MEM_OFF_W + 2;                   // zero bits of a line address

    typedef enum logic [2:0] {
        st_init,                                             // clearing valid and lru bits
        st_idle,                                             // lookup
        st_wb,                                               // dirty victim to l2
        st_refill,                                           // line read from l2
        st_fill                                              // write refilled line
    } state_e;

    state_e                     state;
    logic [`MEM_INDEX_W-1:0]    init_cnt;                    // walk over all sets
    logic                       hit0;
    logic                       hit1;
    logic                       hit;
    logic                       miss;
    logic                       wb_needed;
    way_rd_t                    victim;
    logic [`MEM_LINE_W-1:0]     hit_line;
    logic [`MEM_LINE_W-1:0]     merged_line;
    logic [`MEM_LINE_W-1:0]     fill_line;                   // captured refill data
    logic [`MEM_ADDR_W-1:0]     miss_addr;
    logic [`MEM_ADDR_W-1:0]     vic_addr;
    logic                       drq_q;
    logic                       rw_q;
    logic [`MEM_ADDR_W-1:0]     addr_q;
    logic [`MEM_LINE_W-1:0]     wr_line_q;

    assign hit0 = way0.valid && (way0.tag == req.tag);
    assign hit1 = way1.valid && (way1.tag == req.tag);
    assign hit  = (state == st_idle) && req.access && (hit0 || hit1);
    assign miss = (state == st_idle) && req.access && !(hit0 || hit1);

    assign victim    = lru ? way1 : way0;                    // lru names the victim
    assign wb_needed = victim.valid && victim.dirty;
    assign miss_addr = {req.tag, req.index, {low_w{1'b0}}};
    assign vic_addr  = {victim.tag, req.index, {low_w{1'b0}}};

    assign hit_line = hit1 ? way1.line : way0.line;
    assign rd_word  = hit_line[req.offset*`MEM_WORD_W +: `MEM_WORD_W];

    always_comb begin
        merged_line = hit_line;
        merged_line[req.offset*`MEM_WORD_W +: `MEM_WORD_W] = req.wr_data;  // store merge
    end

    // high through the init walk and for any access not hitting in idle
    assign miss_stall = (state == st_init) || (req.access && !hit);

    assign index = (state == st_init) ? init_cnt : req.index;

    always_comb begin
        wr      = '{way: hit1, tag: req.tag, line: merged_line, dirty: 1'b1, valid: 1'b1};
        wr_en   = 1'b0;
        lru_we  = 1'b0;
        lru_val = ~hit1;                                     // point away from the hit way
        case (state)
            st_init: begin
                wr      = '0;                                // valid 0 clears both ways
                wr_en   = 1'b1;
                lru_we  = 1'b1;
                lru_val = 1'b0;
            end
            st_idle: begin
                wr_en  = hit && req.write;                   // store hit sets dirty
                lru_we = hit;
            end
            st_fill: begin
                wr      = '{way: lru, tag: req.tag, line: fill_line, dirty: 1'b0, valid: 1'b1};
                wr_en   = 1'b1;
                lru_we  = 1'b1;
                lru_val = ~lru;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= st_init;
            init_cnt <= '0;
            drq_q    <= 1'b0;
        end else begin
            case (state)
                st_init: begin
                    init_cnt <= init_cnt + 1'b1;
                    if (&init_cnt) state <= st_idle;         // last set cleared
                end
                st_idle: begin
                    if (miss) begin
                        drq_q <= 1'b1;
                        state <= wb_needed ? st_wb : st_refill;
                    end
                end
                st_wb: begin
                    if (l2_rdy) begin
                        drq_q <= 1'b0;                       // one low cycle before refill
                        state <= st_refill;
                    end
                end
                st_refill: begin
                    if (!drq_q) begin
                        drq_q <= 1'b1;                       // refill after writeback
                    end else if (l2_rdy) begin
                        drq_q <= 1'b0;
                        state <= st_fill;
                    end
                end
                st_fill: state <= st_idle;                   // next lookup hits
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (miss) begin
            rw_q      <= wb_needed;
            addr_q    <= wb_needed ? vic_addr : miss_addr;
            wr_line_q <= victim.line;
        end else if ((state == st_refill) && !drq_q) begin
            rw_q   <= 1'b0;
            addr_q <= miss_addr;
        end
        if ((state == st_refill) && l2_rdy) fill_line <= l2_rd_line;
    end

    assign l2_req = '{drq: drq_q, rw: rw_q, addr: addr_q, wr_line: wr_line_q};

    // request fields hold until the ready pulse, and drop right after it
    a_drq_hold: assert property (@(posedge clk) disable iff (!rst_n)
        l2_req.drq && !l2_rdy |=> l2_req.drq && $stable(l2_req.addr)
                                  && $stable(l2_req.rw) && $stable(l2_req.wr_line));

    a_rdy_drq: assert property (@(posedge clk) disable iff (!rst_n)
        l2_rdy |-> l2_req.drq ##1 !l2_req.drq);

endmodule

`default_nettype wire

//--- dcache/dcache_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_macros.svh"

module dcache_ram (
    input  logic                     clk,
    input  logic [`MEM_INDEX_W-1:0]  index,     // set for read and write
    output mem_pkg::way_rd_t         way0,
    output mem_pkg::way_rd_t         way1,
    output logic                     lru,       // way to replace next
    input  mem_pkg::way_wr_t         wr,
    input  logic                     wr_en,
    input  logic                     lru_we,
    input  logic                     lru_val
);

    localparam int num_sets = 1 << `MEM_INDEX_W;    // 256

    // state bits kept apart from the tag and data arrays
    logic                    valid_mem [2][num_sets];
    logic                    dirty_mem [2][num_sets];
    logic [`MEM_TAG_W-1:0]   tag_mem   [2][num_sets];
    logic [`MEM_LINE_W-1:0]  line_mem  [2][num_sets];
    logic                    lru_mem   [num_sets];    // one bit per set

    // asynchronous read of both ways
    always_comb begin
        way0.valid = valid_mem[0][index];
        way0.dirty = dirty_mem[0][index];
        way0.tag   = tag_mem[0][index];
        way0.line  = line_mem[0][index];
    end

    always_comb begin
        way1.valid = valid_mem[1][index];
        way1.dirty = dirty_mem[1][index];
        way1.tag   = tag_mem[1][index];
        way1.line  = line_mem[1][index];
    end

    assign lru = lru_mem[index];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr.way][index]  <= wr.tag;
            line_mem[wr.way][index] <= wr.line;
            if (wr.valid) begin
                valid_mem[wr.way][index] <= 1'b1;
                dirty_mem[wr.way][index] <= wr.dirty;
            end else begin
                valid_mem[0][index] <= 1'b0;      // set invalidate, both ways
                valid_mem[1][index] <= 1'b0;
                dirty_mem[0][index] <= 1'b0;
                dirty_mem[1][index] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lru_we) lru_mem[index] <= lru_val;   // hit, fill or init
    end

endmodule

`default_nettype wire

//--- rtl/mem_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_macros.svh"

module mem_ctrl (
    input  mem_pkg::ex_mem_t        ex,          // from ex/mem register
    output mem_pkg::cache_req_t     req,         // to dcache_ctrl
    output logic                    miss_align,  // misaligned load or store
    output logic [`MEM_ADDR_W-1:0]  addr_out     // alu result passthrough
);
    import mem_pkg::*;

    localparam int idx_lsb = `MEM_OFF_W + 2;              // above word offset
    localparam int tag_lsb = idx_lsb + `MEM_INDEX_W;

    logic is_mem;                                          // enabled load or store
    logic low_bits;                                        // byte offset nonzero

    always_comb begin
        is_mem     = ex.en && ((ex.op == op_load) || (ex.op == op_store));
        low_bits   = |ex.ex_out[1:0];
        miss_align = is_mem && low_bits;                   // word ops only
    end

    always_comb begin
        req.access  = is_mem && !low_bits;                 // suppressed when misaligned
        req.write   = (ex.op == op_store);
        req.tag     = ex.ex_out[tag_lsb +: `MEM_TAG_W];    // addr[31:12]
        req.index   = ex.ex_out[idx_lsb +: `MEM_INDEX_W];  // addr[11:4]
        req.offset  = ex.ex_out[2 +: `MEM_OFF_W];          // addr[3:2]
        req.wr_data = ex.wr_data;
    end

    assign addr_out = ex.ex_out;                           // result for non-memory ops

endmodule

`default_nettype wire

//--- common/mem_pkg.sv
`default_nettype none

`include "mem_macros.svh"

package mem_pkg;

    typedef enum logic [1:0] {
        op_nop   = `MEM_OP_NOP,
        op_load  = `MEM_OP_LOAD,
        op_store = `MEM_OP_STORE
    } mem_op_e;

    // ex/mem pipeline register
    typedef struct packed {
        logic                        en;        // slot valid
        mem_op_e                     op;
        logic [`MEM_WORD_W-1:0]      wr_data;   // store data
        logic [`MEM_ADDR_W-1:0]      ex_out;    // alu result, also the address
        logic [`MEM_REG_ADDR_W-1:0]  dst_addr;
        logic                        gpr_we;    // active high
    } ex_mem_t;

    // decoded access into the cache
    typedef struct packed {
        logic                        access;    // aligned load or store
        logic                        write;     // store
        logic [`MEM_TAG_W-1:0]       tag;
        logic [`MEM_INDEX_W-1:0]     index;
        logic [`MEM_OFF_W-1:0]       offset;    // word in line
        logic [`MEM_WORD_W-1:0]      wr_data;
    } cache_req_t;

    // mem/wb pipeline register
    typedef struct packed {
        logic                        en;
        logic [`MEM_REG_ADDR_W-1:0]  dst_addr;
        logic                        gpr_we;
        logic [`MEM_WORD_W-1:0]      out;       // load data or alu result
        logic                        miss_align;
    } mem_wb_t;

    // line request toward l2
    typedef struct packed {
        logic                        drq;       // held until l2_rdy
        logic                        rw;        // 1 = writeback
        logic [`MEM_ADDR_W-1:0]      addr;      // line aligned
        logic [`MEM_LINE_W-1:0]      wr_line;
    } l2_req_t;

    // one way as read from storage
    typedef struct packed {
        logic                        valid;
        logic                        dirty;
        logic [`MEM_TAG_W-1:0]       tag;
        logic [`MEM_LINE_W-1:0]      line;
    } way_rd_t;

    // one write into storage
    typedef struct packed {
        logic                        way;       // target way
        logic [`MEM_TAG_W-1:0]       tag;
        logic [`MEM_LINE_W-1:0]      line;
        logic                        dirty;
        logic                        valid;     // 0 invalidates the whole set
    } way_wr_t;

endpackage

`default_nettype wire

//--- common/mem_macros.svh
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// widths of the memory stage
`define MEM_ADDR_W      32      // byte address
`define MEM_WORD_W      32      // data word
`define MEM_TAG_W       20      // addr[31:12]
`define MEM_INDEX_W     8       // addr[11:4], 256 sets
`define MEM_OFF_W       2       // addr[3:2], word in line
`define MEM_LINE_W      128     // four words per line
`define MEM_REG_ADDR_W  5       // gpr address

// memory op encodings
`define MEM_OP_NOP      2'b00   // no access
`define MEM_OP_LOAD     2'b01   // full word load
`define MEM_OP_STORE    2'b10   // full word store

`endif
